// File: rtl/tcb_pkg.sv
// TCB package
// bus widths, memory size and the address word seen flat or decoded

`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // address and data
  localparam int unsigned ADR_W = 32;
  localparam int unsigned DAT_W = 32;
  // one enable per byte lane
  localparam int unsigned BEN_W = DAT_W / 8;

  ////////////////////////////////////////
  // memory size
  ////////////////////////////////////////

  // word index bits, 256 words
  localparam int unsigned MEM_AW = 8;

  // region field width, what is left above the word index
  localparam int unsigned RGN_W = ADR_W - MEM_AW - 2;

  ////////////////////////////////////////
  // address word
  ////////////////////////////////////////

  // manager side sees a flat address
  // memory side splits it into region, word and byte offset
  typedef union packed {
    logic [ADR_W-1:0] flat;
    struct packed {
      // nonzero region is out of range
      logic [RGN_W-1:0]  rgn;
      // word index into the array
      logic [MEM_AW-1:0] idx;
      // byte offset, ignored
      logic [1:0]        off;
    } fld;
  } tcb_adr_u;

endpackage : tcb_pkg

`default_nettype wire

// File: rtl/tcb_if.sv
// TCB interface
// valid/ready request phase, response strobe a fixed DLY cycles after transfer

`timescale 1ns/1ps
`default_nettype none

interface tcb_if
  import tcb_pkg::*;
#(
  // response delay in cycles
  parameter int unsigned DLY = 1
)(
  input wire bus,
  input wire rst_n
);

  ////////////////////////////////////////
  // request
  ////////////////////////////////////////

  logic             vld;
  logic             rdy;
  logic             wen;
  tcb_adr_u         adr;
  logic [BEN_W-1:0] ben;
  logic [DAT_W-1:0] wdt;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // one cycle strobe, DLY cycles after the transfer
  logic             rsp;
  logic [DAT_W-1:0] rdt;
  logic             err;

  // transfer on this edge
  logic trn;
  assign trn = vld & rdy;

  // manager drives the request, gets rdy and the response
  modport man (
    input  bus, rst_n, trn,
    output vld, wen, adr, ben, wdt,
    input  rdy, rsp, rdt, err
  );

  // subordinate is the mirror image
  modport sub (
    input  bus, rst_n, trn,
    input  vld, wen, adr, ben, wdt,
    output rdy, rsp, rdt, err
  );

  // passive observer
  modport mon (
    input  bus, rst_n, trn,
    input  vld, rdy, wen, adr, ben, wdt,
    input  rsp, rdt, err
  );

endinterface : tcb_if

`default_nettype wire

// File: rtl/tcb_req_gen.sv
// TCB request generator
// turns strobed commands into bus transfers, limits what is in flight,
// returns each response as a registered pulse

`timescale 1ns/1ps
`default_nettype none

module tcb_req_gen
  import tcb_pkg::*;
#(
  parameter int unsigned DLY     = 1,
  parameter int unsigned MAX_OUT = 4
)(
  input  wire              bus,
  input  wire              rst_n,
  // command
  input  wire              cmd_vld,
  output logic             cmd_rdy,
  input  wire              cmd_wen,
  input  wire tcb_adr_u    cmd_adr,
  input  wire [BEN_W-1:0]  cmd_ben,
  input  wire [DAT_W-1:0]  cmd_wdt,
  // response
  output logic             rsp_vld,
  output logic [DAT_W-1:0] rsp_rdt,
  output logic             rsp_err,
  // bus
  tcb_if.man               tcb
);

  // slice holds 2, memory pipeline DLY, plus our own register,
  // so more than DLY+3 can never be pending
  localparam int unsigned LIM   = (MAX_OUT < DLY + 3) ? MAX_OUT : DLY + 3;
  localparam int unsigned CNT_W = $clog2(LIM + 1);

  logic             cmd_trn;
  // request register
  logic             req_vld;
  logic             req_wen;
  tcb_adr_u         req_adr;
  logic [BEN_W-1:0] req_ben;
  logic [DAT_W-1:0] req_wdt;
  // transfers on the bus without response
  logic [CNT_W-1:0] out_cnt;
  // in flight plus the one waiting in the register
  logic [CNT_W:0]   pend;

  ////////////////////////////////////////
  // command side
  ////////////////////////////////////////

  assign pend = {1'b0, out_cnt} + {{CNT_W{1'b0}}, req_vld};

  // register free or emptying now, and room for one more
  assign cmd_rdy = (~req_vld | tcb.trn) & (pend < (CNT_W + 1)'(LIM));
  assign cmd_trn = cmd_vld & cmd_rdy;

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      req_vld <= 1'b0;
    end else if (cmd_trn) begin
      req_vld <= 1'b1;
    end else if (tcb.trn) begin
      req_vld <= 1'b0;
    end
  end

  // payload, held until the transfer
  always_ff @(posedge bus) begin
    if (cmd_trn) begin
      req_wen <= cmd_wen;
      req_adr <= cmd_adr;
      req_ben <= cmd_ben;
      req_wdt <= cmd_wdt;
    end
  end

  // drive the bus straight from the register
  assign tcb.vld = req_vld;
  assign tcb.wen = req_wen;
  assign tcb.adr = req_adr;
  assign tcb.ben = req_ben;
  assign tcb.wdt = req_wdt;

  ////////////////////////////////////////
  // outstanding count
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt <= '0;
    end else begin
      case ({tcb.trn, tcb.rsp})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: out_cnt <= out_cnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= tcb.rsp;
    end
  end

  // data and error only valid with rsp_vld
  always_ff @(posedge bus) begin
    if (tcb.rsp) begin
      rsp_rdt <= tcb.rdt;
      rsp_err <= tcb.err;
    end
  end

endmodule : tcb_req_gen

`default_nettype wire

// File: rtl/tcb_slice.sv
// TCB request slice
// two entry skid buffer, registers vld and rdy, response passes straight back

`timescale 1ns/1ps
`default_nettype none

module tcb_slice
  import tcb_pkg::*;
(
  tcb_if.sub tcb_up,
  tcb_if.man tcb_dn
);

  // fill count, 0 to 2
  logic [1:0]       cnt;
  // main entry, drives downstream
  logic             main_wen;
  tcb_adr_u         main_adr;
  logic [BEN_W-1:0] main_ben;
  logic [DAT_W-1:0] main_wdt;
  // spare entry, catches the request taken during a stall
  logic             spr_wen;
  tcb_adr_u         spr_adr;
  logic [BEN_W-1:0] spr_ben;
  logic [DAT_W-1:0] spr_wdt;

  ////////////////////////////////////////
  // fill count
  ////////////////////////////////////////

  always_ff @(posedge tcb_up.bus or negedge tcb_up.rst_n) begin
    if (!tcb_up.rst_n) begin
      cnt <= 2'd0;
    end else begin
      case ({tcb_up.trn, tcb_dn.trn})
        2'b10:   cnt <= cnt + 2'd1;
        2'b01:   cnt <= cnt - 2'd1;
        default: cnt <= cnt;
      endcase
    end
  end

  // both straight from the count register
  // no path from downstream rdy to upstream rdy
  assign tcb_up.rdy = ~cnt[1];
  assign tcb_dn.vld = |cnt;

  ////////////////////////////////////////
  // entries
  ////////////////////////////////////////

  always_ff @(posedge tcb_up.bus) begin
    // empty, or one leaving as one arrives
    if (tcb_up.trn && (cnt == 2'd0 || (cnt == 2'd1 && tcb_dn.trn))) begin
      main_wen <= tcb_up.wen;
      main_adr <= tcb_up.adr;
      main_ben <= tcb_up.ben;
      main_wdt <= tcb_up.wdt;
    end else if (tcb_dn.trn && cnt == 2'd2) begin
      // spare moves up
      main_wen <= spr_wen;
      main_adr <= spr_adr;
      main_ben <= spr_ben;
      main_wdt <= spr_wdt;
    end
    // main stalled, park the new one
    if (tcb_up.trn && cnt == 2'd1 && !tcb_dn.trn) begin
      spr_wen <= tcb_up.wen;
      spr_adr <= tcb_up.adr;
      spr_ben <= tcb_up.ben;
      spr_wdt <= tcb_up.wdt;
    end
  end

  assign tcb_dn.wen = main_wen;
  assign tcb_dn.adr = main_adr;
  assign tcb_dn.ben = main_ben;
  assign tcb_dn.wdt = main_wdt;

  // responses keep transfer order, nothing to store
  assign tcb_up.rsp = tcb_dn.rsp;
  assign tcb_up.rdt = tcb_dn.rdt;
  assign tcb_up.err = tcb_dn.err;

endmodule : tcb_slice

`default_nettype wire

// File: rtl/tcb_mem.sv
// TCB memory
// 256 word array, region check, read-modify-write for partial writes,
// response through a DLY stage pipeline

`timescale 1ns/1ps
`default_nettype none

module tcb_mem
  import tcb_pkg::*;
#(
  parameter int unsigned DLY = 1
)(
  tcb_if.sub tcb
);

  // storage, not reset
  logic [DAT_W-1:0] mem_q [2**MEM_AW];

  logic             rgn_err;
  logic [DAT_W-1:0] rd_word;
  logic             need_rmw;
  logic             rmw_q;
  logic [DAT_W-1:0] rmw_dat;
  logic [DAT_W-1:0] wr_dat;
  logic [DAT_W-1:0] rsp_dat;
  // response pipeline
  logic [DLY-1:0]   pip_vld;
  logic [DLY-1:0]   pip_err;
  logic [DAT_W-1:0] pip_rdt [DLY];

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  // only region 0 is backed by memory
  assign rgn_err = |tcb.adr.fld.rgn;
  assign rd_word = mem_q[tcb.adr.fld.idx];

  // write with a byte lane off
  assign need_rmw = tcb.vld & tcb.wen & ~(&tcb.ben);

  // first cycle reads, second cycle merges and writes
  assign tcb.rdy = ~need_rmw | rmw_q;

  always_ff @(posedge tcb.bus or negedge tcb.rst_n) begin
    if (!tcb.rst_n) begin
      rmw_q <= 1'b0;
    end else begin
      rmw_q <= need_rmw & ~rmw_q;
    end
  end

  // old word, captured in the stall cycle
  always_ff @(posedge tcb.bus) begin
    if (need_rmw && !rmw_q) begin
      rmw_dat <= rd_word;
    end
  end

  ////////////////////////////////////////
  // write
  ////////////////////////////////////////

  // enabled lanes from wdt, the rest from the old word
  always_comb begin
    for (int b = 0; b < BEN_W; b++) begin
      wr_dat[8*b +: 8] = tcb.ben[b] ? tcb.wdt[8*b +: 8] : rmw_dat[8*b +: 8];
    end
  end

  always_ff @(posedge tcb.bus) begin
    if (tcb.trn && tcb.wen && !rgn_err) begin
      mem_q[tcb.adr.fld.idx] <= wr_dat;
    end
  end

  ////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////

  // reads return the word, writes and errors return zero
  assign rsp_dat = (tcb.wen || rgn_err) ? '0 : rd_word;

  always_ff @(posedge tcb.bus or negedge tcb.rst_n) begin
    if (!tcb.rst_n) begin
      pip_vld <= '0;
    end else begin
      pip_vld[0] <= tcb.trn;
      for (int i = 1; i < DLY; i++) begin
        pip_vld[i] <= pip_vld[i-1];
      end
    end
  end

  always_ff @(posedge tcb.bus) begin
    pip_rdt[0] <= rsp_dat;
    pip_err[0] <= rgn_err;
    for (int i = 1; i < DLY; i++) begin
      pip_rdt[i] <= pip_rdt[i-1];
      pip_err[i] <= pip_err[i-1];
    end
  end

  // last stage, DLY cycles after the transfer
  assign tcb.rsp = pip_vld[DLY-1];
  assign tcb.rdt = pip_rdt[DLY-1];
  assign tcb.err = pip_err[DLY-1];

endmodule : tcb_mem

`default_nettype wire

// File: rtl/tcb_top.sv
// TCB subsystem top
// request generator, skid slice and memory joined by two bus instances

`timescale 1ns/1ps
`default_nettype none

module tcb_top
  import tcb_pkg::*;
#(
  parameter int unsigned DLY     = 1,
  parameter int unsigned MAX_OUT = 4
)(
  input  wire              bus,
  input  wire              rst_n,
  // command
  input  wire              cmd_vld,
  output logic             cmd_rdy,
  input  wire              cmd_wen,
  input  wire tcb_adr_u    cmd_adr,
  input  wire [BEN_W-1:0]  cmd_ben,
  input  wire [DAT_W-1:0]  cmd_wdt,
  // response
  output logic             rsp_vld,
  output logic [DAT_W-1:0] rsp_rdt,
  output logic             rsp_err
);

  ////////////////////////////////////////
  // buses
  ////////////////////////////////////////

  // manager to slice
  tcb_if #(.DLY(DLY)) tcb_m (.bus(bus), .rst_n(rst_n));
  // slice to memory
  tcb_if #(.DLY(DLY)) tcb_s (.bus(bus), .rst_n(rst_n));

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  tcb_req_gen #(
    .DLY     (DLY),
    .MAX_OUT (MAX_OUT)
  ) req_gen_i (
    .bus     (bus),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .cmd_wen (cmd_wen),
    .cmd_adr (cmd_adr),
    .cmd_ben (cmd_ben),
    .cmd_wdt (cmd_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_err (rsp_err),
    .tcb     (tcb_m.man)
  );

  // breaks the rdy path between manager and memory
  tcb_slice slice_i (
    .tcb_up (tcb_m.sub),
    .tcb_dn (tcb_s.man)
  );

  tcb_mem #(
    .DLY (DLY)
  ) mem_i (
    .tcb (tcb_s.sub)
  );

endmodule : tcb_top

`default_nettype wire

// File: test/tcb_tb.sv
// TCB subsystem testbench
// directed tests against a reference memory, responses checked in command order

`timescale 1ns/1ps
`default_nettype none

module tcb_tb
  import tcb_pkg::*;
();

  localparam int DLY     = 2;
  localparam int MAX_OUT = 4;
  // cycles any single wait may take
  localparam int TMO     = 200;

  logic             bus;
  logic             rst_n;
  logic             cmd_vld;
  logic             cmd_rdy;
  logic             cmd_wen;
  tcb_adr_u         cmd_adr;
  logic [BEN_W-1:0] cmd_ben;
  logic [DAT_W-1:0] cmd_wdt;
  logic             rsp_vld;
  logic [DAT_W-1:0] rsp_rdt;
  logic             rsp_err;

  // reference memory and expected responses, oldest first
  logic [DAT_W-1:0] ref_mem [2**MEM_AW];
  logic [DAT_W-1:0] exp_rdt_q [$];
  logic             exp_err_q [$];

  logic [31:0] seed;
  int          err_cnt;
  int          acc_cnt;
  int          rsp_cnt;
  int          test_cnt;
  int          test_fail;

  ////////////////////////////////////////
  // clock and DUT
  ////////////////////////////////////////

  initial bus = 1'b0;
  always #20 bus = ~bus;

  tcb_top #(
    .DLY     (DLY),
    .MAX_OUT (MAX_OUT)
  ) dut_i (
    .bus     (bus),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .cmd_wen (cmd_wen),
    .cmd_adr (cmd_adr),
    .cmd_ben (cmd_ben),
    .cmd_wdt (cmd_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_err (rsp_err)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // 32 bit LCG
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic tcb_adr_u make_adr(input logic [RGN_W-1:0] rgn,
                                        input logic [MEM_AW-1:0] idx);
    tcb_adr_u a;
    a.fld.rgn = rgn;
    a.fld.idx = idx;
    a.fld.off = 2'b00;
    return a;
  endfunction

  task automatic compare_dat(input logic [DAT_W-1:0] got, input logic [DAT_W-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s rdt %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s err %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_adr(input tcb_adr_u got, input tcb_adr_u exp, input string what);
    if (got.flat !== exp.flat) begin
      $display("MISMATCH at %0d ns: %s adr %h, expected %h", $time, what, got.flat, exp.flat);
      err_cnt++;
    end
  endtask

  // one command, waits for cmd_rdy, leaves at 2 ns after the accepting edge
  task automatic issue(input logic wen, input tcb_adr_u adr, input logic [BEN_W-1:0] ben,
                       input logic [DAT_W-1:0] wdt);
    int                n;
    logic [DAT_W-1:0]  word;
    logic [RGN_W-1:0]  rgn;
    logic [MEM_AW-1:0] idx;
    cmd_vld = 1'b1;
    cmd_wen = wen;
    cmd_adr = adr;
    cmd_ben = ben;
    cmd_wdt = wdt;
    // region above the word index, word index above the byte offset
    rgn = adr.flat[ADR_W-1:MEM_AW+2];
    idx = adr.flat[MEM_AW+1:2];
    n = 0;
    while (cmd_rdy !== 1'b1 && n < TMO) begin
      @(posedge bus);
      #2;
      n++;
    end
    if (cmd_rdy !== 1'b1) begin
      $display("timeout at %0d ns: cmd_rdy stayed low for %0d cycles", $time, TMO);
      err_cnt++;
      cmd_vld = 1'b0;
    end else begin
      @(posedge bus);
      #2;
      cmd_vld = 1'b0;
      acc_cnt++;
      // expected response, memory handles commands in order
      if (rgn != '0) begin
        exp_rdt_q.push_back('0);
        exp_err_q.push_back(1'b1);
      end else if (wen) begin
        word = ref_mem[idx];
        for (int b = 0; b < BEN_W; b++) begin
          if (ben[b]) word[8*b +: 8] = wdt[8*b +: 8];
        end
        ref_mem[idx] = word;
        exp_rdt_q.push_back('0);
        exp_err_q.push_back(1'b0);
      end else begin
        exp_rdt_q.push_back(ref_mem[idx]);
        exp_err_q.push_back(1'b0);
      end
    end
  endtask

  // until every accepted command has its response
  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_rdt_q.size() != 0 && n < TMO) begin
      @(posedge bus);
      #2;
      n++;
    end
    if (exp_rdt_q.size() != 0) begin
      $display("timeout at %0d ns: %0d responses never came", $time, exp_rdt_q.size());
      err_cnt++;
      exp_rdt_q.delete();
      exp_err_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("%s: PASS", name);
    end else begin
      test_fail++;
      $display("%s: FAIL, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // response checker
  ////////////////////////////////////////

  // mid cycle, away from the edge
  always @(negedge bus) begin
    if (rst_n === 1'b1 && rsp_vld === 1'b1) begin
      rsp_cnt++;
      if (exp_rdt_q.size() == 0) begin
        $display("error at %0d ns: response with no command outstanding", $time);
        err_cnt++;
      end else begin
        compare_dat(rsp_rdt, exp_rdt_q.pop_front(), "response");
        compare_err(rsp_err, exp_err_q.pop_front(), "response");
      end
    end
    if (acc_cnt - rsp_cnt > MAX_OUT) begin
      $display("MISMATCH at %0d ns: %0d commands outstanding, limit %0d", $time,
               acc_cnt - rsp_cnt, MAX_OUT);
      err_cnt++;
    end
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    int e;
    e = err_cnt;
    if (cmd_rdy !== 1'b1) begin
      $display("MISMATCH at %0d ns: cmd_rdy %b after reset, expected 1", $time, cmd_rdy);
      err_cnt++;
    end
    // idle, nothing may come back
    for (int i = 0; i < 10; i++) begin
      if (rsp_vld !== 1'b0) begin
        $display("MISMATCH at %0d ns: rsp_vld %b while idle, expected 0", $time, rsp_vld);
        err_cnt++;
      end
      @(posedge bus);
      #2;
    end
    end_test("reset_state", e);
  endtask

  task automatic test_write_read();
    int e;
    e = err_cnt;
    for (int i = 0; i < 8; i++) begin
      issue(1'b1, make_adr('0, MEM_AW'(i * 5 + 3)), '1, next_rand());
    end
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, make_adr('0, MEM_AW'(i * 5 + 3)), '1, '0);
    end
    wait_idle();
    end_test("write_read", e);
  endtask

  task automatic test_byte_merge();
    int               e;
    logic [BEN_W-1:0] ben_l [6];
    e = err_cnt;
    ben_l = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0101, 4'b0000};
    issue(1'b1, make_adr('0, 8'd40), '1, 32'h1122_3344);
    // read back after every partial write
    for (int i = 0; i < 6; i++) begin
      issue(1'b1, make_adr('0, 8'd40), ben_l[i], next_rand());
      issue(1'b0, make_adr('0, 8'd40), '1, '0);
    end
    wait_idle();
    end_test("byte_merge", e);
  endtask

  task automatic test_range_err();
    int       e;
    tcb_adr_u a;
    tcb_adr_u x;
    e = err_cnt;
    issue(1'b1, make_adr('0, 8'd60), '1, 32'hcafe_0060);
    // region 1, same word index
    a = make_adr(RGN_W'(1), 8'd60);
    x.flat = (ADR_W'(1) << (MEM_AW + 2)) | (ADR_W'(60) << 2);
    compare_adr(a, x, "region 1 address");
    issue(1'b1, a, '1, 32'hdead_beef);
    issue(1'b0, a, '1, '0);
    // top region, partial write stalls but still errors
    a = make_adr({RGN_W{1'b1}}, 8'd60);
    x.flat = {{RGN_W{1'b1}}, 8'd60, 2'b00};
    compare_adr(a, x, "top region address");
    issue(1'b1, a, 4'b0011, 32'h5555_aaaa);
    issue(1'b0, a, '1, '0);
    // region 0 word untouched
    issue(1'b0, make_adr('0, 8'd60), '1, '0);
    wait_idle();
    end_test("range_error", e);
  endtask

  task automatic test_random();
    int               e;
    int               n0;
    logic [31:0]      r;
    logic [BEN_W-1:0] bn;
    logic [RGN_W-1:0] rg;
    e  = err_cnt;
    n0 = rsp_cnt;
    // known contents for the 16 words in use
    for (int i = 0; i < 16; i++) begin
      issue(1'b1, make_adr('0, MEM_AW'(i)), '1, next_rand());
    end
    for (int i = 0; i < 64; i++) begin
      r  = next_rand();
      bn = r[23:20];
      if (r[19]) bn = '1;
      rg = '0;
      if (r[18:16] == 3'b111) rg = RGN_W'({r[15:12], 1'b1});
      issue(r[28], make_adr(rg, {4'h0, r[27:24]}), bn, next_rand());
    end
    wait_idle();
    if (rsp_cnt - n0 != 80) begin
      $display("MISMATCH at %0d ns: %0d responses for 80 commands", $time, rsp_cnt - n0);
      err_cnt++;
    end
    end_test("random_traffic", e);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    seed      = 32'd36319;
    err_cnt   = 0;
    acc_cnt   = 0;
    rsp_cnt   = 0;
    test_cnt  = 0;
    test_fail = 0;
    rst_n     = 1'b0;
    cmd_vld   = 1'b0;
    cmd_wen   = 1'b0;
    cmd_adr   = '0;
    cmd_ben   = '0;
    cmd_wdt   = '0;
    repeat (4) @(posedge bus);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_write_read();
    test_byte_merge();
    test_range_err();
    test_random();
    $display("summary: %0d tests, %0d ok, %0d failing, %0d errors", test_cnt,
             test_cnt - test_fail, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // last resort if the sequence itself stalls
  initial begin
    #2_000_000;
    $display("run stopped by the watchdog at %0d ns", $time);
    $display("test failed");
    $finish;
  end

endmodule : tcb_tb

`default_nettype wire

// File: vlog.f
rtl/tcb_pkg.sv
rtl/tcb_if.sv
rtl/tcb_req_gen.sv
rtl/tcb_slice.sv
rtl/tcb_mem.sv
rtl/tcb_top.sv
test/tcb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the TCB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tcb_tb --Mdir obj_dir -o tcb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tcb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict comes from the log
if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
